/* sim.f */
source/mcpu_pkg.sv
source/mcpu_clkrst.sv
source/mcpu_pad_in.sv
source/mcpu_apb_decode.sv
source/mcpu_gpio_regs.sv
source/mcpu_scratch_mem.sv
source/mcpu_board.sv
tests/tb_clk.sv
tests/mcpu_board_assert.sv
tests/tb_mcpu_board.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mcpu_board -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past assertion failures so the testbench can report them
out=$(./obj_dir/Vtb_mcpu_board +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'TEST OK'; then
  exit 0
fi
echo "Pass message not found"
exit 1

/* tests/tb_mcpu_board.sv */
`timescale 1ns/1ns

module tb_mcpu_board;

  localparam int mem_words  = 256;
  localparam int rst_hold   = 16;
  localparam int max_cycles = 4000;               // Reset, clear, holds and traffic, doubled
  localparam logic [11:0] ledr_addr = {1'b0, mcpu_pkg::gpio_ledr_off};
  localparam logic [11:0] ledg_addr = {1'b0, mcpu_pkg::gpio_ledg_off};
  localparam logic [11:0] in_addr   = {1'b0, mcpu_pkg::gpio_in_off};

  logic               clk50;
  logic               rst_n;
  logic [9:0]         sw;
  logic [3:0]         key;
  logic               uart_rx_pad;
  mcpu_pkg::apb_req_t apb_req;
  mcpu_pkg::apb_rsp_t apb_rsp;
  logic [9:0]         ledr;
  logic [7:0]         ledg;
  logic               core_ready;

  int          err_cnt = 0;
  int          test_errs = 0;                     // err_cnt when the current test began
  int          test_cnt = 0;
  int          test_fail = 0;
  int          cycles = 0;
  logic [31:0] mem_model [mem_words];             // Expected memory contents
  bit          written   [mem_words];
  logic [9:0]  ledr_exp;
  logic [7:0]  ledg_exp;

  tb_clk tb_clk_i (.clk50(clk50));

  mcpu_board #(
    .mem_words (mem_words),
    .rst_hold  (rst_hold)
  ) mcpu_board_i (
    .clk50       (clk50),
    .rst_n       (rst_n),
    .sw          (sw),
    .key         (key),
    .uart_rx_pad (uart_rx_pad),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .ledr        (ledr),
    .ledg        (ledg),
    .core_ready  (core_ready)
  );

  // Watchdog
  always @(posedge clk50) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Run stopped after %0d cycles, a wait never ended", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [11:0] word_addr(input int idx);
    return {1'b1, idx[8:0], 2'b00};               // Word address in the memory half
  endfunction

  task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, sig, exp, act);
      err_cnt++;
    end
  endtask

  // One APB transfer driven on falling edges
  task automatic run_transfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    int waits;
    waits = 0;
    @(negedge clk50);
    apb_req.paddr   = addr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.pwdata  = wdata;
    @(negedge clk50);
    apb_req.penable = 1'b1;
    #1;                                           // Response settled by mid cycle
    while (!apb_rsp.pready && waits < 8) begin
      @(negedge clk50);
      #1;
      waits++;
    end
    assert (apb_rsp.pready) else begin
      $display("APB transfer to %h got no pready within 8 cycles", addr);
      err_cnt++;
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk50);                             // Completing edge has passed
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    run_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    run_transfer(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic expect_write(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
    logic err;
    apb_write(addr, data, err);
    check_value("pslverr", 32'(exp_err), 32'(err));
  endtask

  task automatic expect_read(input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_value("pslverr", 32'h0, 32'(err));
    check_value("prdata", exp, data);
  endtask

  task automatic wait_ready(input int limit, output int waited);
    waited = 0;
    while (!core_ready && waited < limit) begin
      @(negedge clk50);
      waited++;
    end
    assert (core_ready) else begin
      $display("core_ready still low after %0d cycles", limit);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt == test_errs) begin
      $display("%s: passed", name);
    end else begin
      test_fail++;
      $display("%s: failed with %0d errors", name, err_cnt - test_errs);
    end
    test_errs = err_cnt;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] rdata;
    logic        err;
    int          idx;
    int          waited;
    int          assert_fails;
    rnd = $urandom(59033);                        // Seed once
    rst_n       = 1'b0;
    sw          = '0;
    key         = 4'hf;                           // All released
    uart_rx_pad = 1'b1;
    apb_req     = '0;
    ledr_exp    = '0;
    ledg_exp    = '0;
    for (int i = 0; i < mem_words; i++) begin
      mem_model[i] = 32'h0;                       // Cleared after reset
      written[i]   = 1'b0;
    end
    repeat (16) @(negedge clk50);
    rst_n = 1'b1;

    // Clear and hold before core_ready
    wait_ready(mem_words + rst_hold + 64, waited);
    // Seen one falling edge after clear and hold
    check_value("core_ready rise cycle", 32'(mem_words + rst_hold + 1), 32'(waited));
    for (int i = 0; i < 4; i++) begin
      expect_read(word_addr(i), 32'h0);
    end
    expect_read(word_addr(mem_words - 1), 32'h0);
    finish_test("reset_init");

    for (int i = 0; i < 8; i++) begin
      rnd      = $urandom();
      ledr_exp = rnd[9:0];                        // Upper bits dropped
      expect_write(ledr_addr, rnd, 1'b0);
      check_value("ledr", 32'(ledr_exp), 32'(ledr));
      expect_read(ledr_addr, 32'(ledr_exp));
      rnd      = $urandom();
      ledg_exp = rnd[7:0];
      expect_write(ledg_addr, rnd, 1'b0);
      check_value("ledg", 32'(ledg_exp), 32'(ledg));
      expect_read(ledg_addr, 32'(ledg_exp));
    end
    finish_test("led_regs");

    for (int i = 0; i < 4; i++) begin
      rnd = $urandom();
      @(negedge clk50);
      sw          = rnd[9:0];
      key         = {rnd[12:10], 1'b1};           // Key 0 stays up
      uart_rx_pad = rnd[13];
      repeat (6) @(negedge clk50);                // Past the UART shifter
      expect_read(in_addr, {17'b0, uart_rx_pad, ~key, sw});
    end
    finish_test("input_status");

    for (int i = 0; i < 32; i++) begin
      idx            = $urandom_range(mem_words - 1, 0);
      rnd            = $urandom();
      mem_model[idx] = rnd;
      written[idx]   = 1'b1;
      expect_write(word_addr(idx), rnd, 1'b0);
    end
    for (int i = 0; i < mem_words; i++) begin
      if (written[i]) begin
        expect_read(word_addr(i), mem_model[i]);
      end
    end
    for (int i = 0; i < 8; i++) begin
      do begin
        idx = $urandom_range(mem_words - 1, 0);
      end while (written[idx]);
      expect_read(word_addr(idx), 32'h0);         // Never written
    end
    finish_test("memory");

    expect_write(12'h00c, $urandom(), 1'b1);      // Unmapped GPIO offset
    apb_read(12'h010, rdata, err);
    check_value("pslverr", 32'h1, 32'(err));
    expect_write(in_addr, 32'hffff_ffff, 1'b1);   // Status is read only
    expect_read(ledr_addr, 32'(ledr_exp));
    expect_read(ledg_addr, 32'(ledg_exp));
    expect_read(in_addr, {17'b0, uart_rx_pad, ~key, sw});
    expect_write(word_addr(mem_words), $urandom(), 1'b1);
    apb_read(word_addr(mem_words), rdata, err);
    check_value("pslverr", 32'h1, 32'(err));
    expect_read(word_addr(0), mem_model[0]);      // Same low index bits
    finish_test("errors");

    expect_write(ledr_addr, 32'h2a5, 1'b0);       // Known nonzero LEDs before the press
    expect_write(ledg_addr, 32'h5a, 1'b0);
    @(negedge clk50);
    key    = 4'b1110;                             // Press key 0
    waited = 0;
    while (core_ready && waited < 8) begin
      @(negedge clk50);
      waited++;
    end
    assert (!core_ready) else begin
      $display("core_ready did not drop while key 0 was pressed");
      err_cnt++;
    end
    check_value("core_ready fall cycle", 32'd3, 32'(waited));  // Two sync stages then the drop
    check_value("ledr", 32'h0, 32'(ledr));
    check_value("ledg", 32'h0, 32'(ledg));
    ledr_exp = '0;
    ledg_exp = '0;
    repeat (4) @(negedge clk50);
    key = 4'hf;
    wait_ready(rst_hold + 16, waited);
    check_value("core_ready rise cycle", 32'(rst_hold + 2), 32'(waited));  // Sync stages then hold
    for (int i = 0; i < mem_words; i++) begin
      if (written[i]) begin
        expect_read(word_addr(i), mem_model[i]);  // Memory kept its data
      end
    end
    expect_read(ledr_addr, 32'(ledr_exp));
    expect_read(ledg_addr, 32'(ledg_exp));
    finish_test("button_reset");

    assert_fails = mcpu_board_i.mcpu_board_assert_i.fail_cnt;
    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             test_cnt, test_fail, err_cnt, assert_fails);
    if (err_cnt == 0 && test_fail == 0 && assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tests/mcpu_board_assert.sv */
`timescale 1ns/1ns

module mcpu_board_assert #(
  parameter int rst_hold = 16
) (
  input logic               clk50,
  input logic               rst_n,
  input logic               mem_ready,
  input logic               reset_button,         // Conditioned key 0
  input logic               core_rst_n,
  input logic               core_ready,
  input logic [9:0]         ledr,
  input logic [7:0]         ledg,
  input mcpu_pkg::apb_req_t apb_req,
  input mcpu_pkg::apb_rsp_t apb_rsp,
  input mcpu_pkg::apb_req_t gpio_req,
  input mcpu_pkg::apb_rsp_t gpio_rsp,
  input mcpu_pkg::apb_req_t mem_req,
  input mcpu_pkg::apb_rsp_t mem_rsp
);

  int   fail_cnt = 0;                             // Tally, read by the testbench
  logic hold_ok;

  assign hold_ok = mem_ready & ~reset_button;     // Hold count runs only here

  // GPIO answers in the first access cycle
  gpio_ready_a: assert property (@(posedge clk50) disable iff (!core_rst_n)
    gpio_req.psel && !gpio_req.penable |=> gpio_rsp.pready)
    else begin $error("GPIO pready not in first access cycle"); fail_cnt++; end

  // Memory has exactly one wait state
  mem_ready_a: assert property (@(posedge clk50) disable iff (!rst_n)
    mem_req.psel && !mem_req.penable |=> !mem_rsp.pready ##1 mem_rsp.pready)
    else begin $error("Memory pready not in second access cycle"); fail_cnt++; end

  // Outputs quiet in any reset
  reset_out_a: assert property (@(posedge clk50)
    !rst_n || !core_rst_n |-> ledr == '0 && ledg == '0 && !core_ready)
    else begin $error("LEDs or core_ready active during reset"); fail_cnt++; end

  // Release exactly rst_hold cycles into the hold
  hold_a: assert property (@(posedge clk50) disable iff (!rst_n)
    $rose(hold_ok) |-> ##(rst_hold) $rose(core_rst_n))
    else begin $error("core_rst_n release not rst_hold cycles after ready"); fail_cnt++; end

  // Host holds the request until pready
  stable_a: assert property (@(posedge clk50) disable iff (!rst_n)
    apb_req.psel && !apb_rsp.pready |=> apb_req.psel && $stable(apb_req.paddr)
      && $stable(apb_req.pwrite) && $stable(apb_req.pwdata))
    else begin $error("APB request changed before pready"); fail_cnt++; end

  setup_a: assert property (@(posedge clk50) disable iff (!rst_n)
    apb_req.psel && !apb_req.penable |=> apb_req.penable)
    else begin $error("APB setup not followed by access"); fail_cnt++; end

  // No traffic while the core is held
  host_a: assert property (@(posedge clk50) disable iff (!rst_n)
    apb_req.psel |-> core_ready)
    else begin $error("APB transfer while core_ready low"); fail_cnt++; end

endmodule

bind mcpu_board mcpu_board_assert #(
  .rst_hold (rst_hold)
) mcpu_board_assert_i (
  .clk50        (clk50),
  .rst_n        (rst_n),
  .mem_ready    (mem_ready),
  .reset_button (pad_in.buttons[0]),
  .core_rst_n   (core_rst_n),
  .core_ready   (core_ready),
  .ledr         (ledr),
  .ledg         (ledg),
  .apb_req      (apb_req),
  .apb_rsp      (apb_rsp),
  .gpio_req     (gpio_req),
  .gpio_rsp     (gpio_rsp),
  .mem_req      (mem_req),
  .mem_rsp      (mem_rsp)
);

/* tests/tb_clk.sv */
`timescale 1ns/1ns

module tb_clk (
  output logic clk50
);

  localparam int half_period = 2;                 // 4 ns period

  initial begin
    clk50 = 1'b0;
    forever begin
      #half_period clk50 = ~clk50;
    end
  end

endmodule

/* source/mcpu_board.sv */
`timescale 1ns/1ns

module mcpu_board #(
  parameter int mem_words = 256,
  parameter int rst_hold  = 16
) (
  input  logic               clk50,              // Straight from the pad
  input  logic               rst_n,
  input  logic [9:0]         sw,
  input  logic [3:0]         key,
  input  logic               uart_rx_pad,
  input  mcpu_pkg::apb_req_t apb_req,
  output mcpu_pkg::apb_rsp_t apb_rsp,
  output logic [9:0]         ledr,
  output logic [7:0]         ledg,
  output logic               core_ready
);

  mcpu_pkg::pad_in_t  pad_in;
  mcpu_pkg::apb_req_t gpio_req;
  mcpu_pkg::apb_rsp_t gpio_rsp;
  mcpu_pkg::apb_req_t mem_req;
  mcpu_pkg::apb_rsp_t mem_rsp;
  logic               mem_ready;
  logic               core_rst_n;

  assign core_ready = core_rst_n;                 // Host may start transfers

  // Input conditioning
  mcpu_pad_in mcpu_pad_in_i (
    .clk50       (clk50),
    .rst_n       (rst_n),
    .sw          (sw),
    .key         (key),
    .uart_rx_pad (uart_rx_pad),
    .pad_in      (pad_in)
  );

  // Core reset sequencing, button 0 is the soft reset
  mcpu_clkrst #(
    .rst_hold (rst_hold)
  ) mcpu_clkrst_i (
    .clk50        (clk50),
    .rst_n        (rst_n),
    .mem_ready    (mem_ready),
    .reset_button (pad_in.buttons[0]),
    .core_rst_n   (core_rst_n)
  );

  mcpu_apb_decode mcpu_apb_decode_i (
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .gpio_req (gpio_req),
    .gpio_rsp (gpio_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
  );

  mcpu_gpio_regs mcpu_gpio_regs_i (
    .clk50      (clk50),
    .core_rst_n (core_rst_n),
    .apb_req    (gpio_req),
    .apb_rsp    (gpio_rsp),
    .pad_in     (pad_in),
    .ledr       (ledr),
    .ledg       (ledg)
  );

  // Memory stays on the pad reset so contents survive a button reset
  mcpu_scratch_mem #(
    .mem_words (mem_words)
  ) mcpu_scratch_mem_i (
    .clk50     (clk50),
    .rst_n     (rst_n),
    .apb_req   (mem_req),
    .apb_rsp   (mem_rsp),
    .mem_ready (mem_ready)
  );

endmodule

/* source/mcpu_scratch_mem.sv */
`timescale 1ns/1ns

module mcpu_scratch_mem #(
  parameter int mem_words = 256                   // Power of two, at most 512
) (
  input  logic               clk50,
  input  logic               rst_n,
  input  mcpu_pkg::apb_req_t apb_req,
  output mcpu_pkg::apb_rsp_t apb_rsp,
  output logic               mem_ready
);

  localparam int idx_w = $clog2(mem_words);

  logic [31:0]    mem [mem_words];
  logic [idx_w:0] clr_ptr;                        // Extra bit flags clear done
  logic           clear_en;
  logic [8:0]     word_idx;                       // paddr bits 10:2
  logic           in_range;
  logic           access;
  logic           first_acc;                      // Wait state cycle
  logic           wait_q;                         // Second access cycle follows
  logic           pready;
  logic           wr_en;
  logic [31:0]    rdata_q;

  assign clear_en  = ~mem_ready & ~clr_ptr[idx_w];
  assign word_idx  = apb_req.paddr[10:2];
  assign in_range  = (word_idx < mem_words);
  assign access    = apb_req.psel & apb_req.penable;
  assign first_acc = access & ~wait_q & mem_ready;  // No service during clear
  assign pready    = access & wait_q;
  assign wr_en     = pready & apb_req.pwrite & in_range;  // Bad index write dropped

  // Clear sequence and wait state control
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      clr_ptr   <= '0;
      mem_ready <= 1'b0;
      wait_q    <= 1'b0;
    end else begin
      if (!mem_ready) begin
        if (clr_ptr[idx_w]) begin
          mem_ready <= 1'b1;                      // Edge after last word cleared
        end else begin
          clr_ptr <= clr_ptr + 1'b1;
        end
      end
      if (first_acc) begin
        wait_q <= 1'b1;
      end else if (pready || !apb_req.psel) begin
        wait_q <= 1'b0;
      end
    end
  end

  // Single write port shared by clear and APB
  always_ff @(posedge clk50) begin
    if (clear_en) begin
      mem[clr_ptr[idx_w-1:0]] <= '0;
    end else if (wr_en) begin
      mem[word_idx[idx_w-1:0]] <= apb_req.pwdata;
    end
  end

  // Registered read during the wait state
  always_ff @(posedge clk50) begin
    if (first_acc) begin
      rdata_q <= mem[word_idx[idx_w-1:0]];
    end
  end

  assign apb_rsp.prdata  = rdata_q;
  assign apb_rsp.pready  = pready;
  assign apb_rsp.pslverr = pready & ~in_range;

endmodule

/* source/mcpu_gpio_regs.sv */
`timescale 1ns/1ns

module mcpu_gpio_regs (
  input  logic               clk50,
  input  logic               core_rst_n,
  input  mcpu_pkg::apb_req_t apb_req,
  output mcpu_pkg::apb_rsp_t apb_rsp,
  input  mcpu_pkg::pad_in_t  pad_in,
  output logic [9:0]         ledr,
  output logic [7:0]         ledg
);

  logic        access;                            // Access phase, always zero wait
  logic        hit_ledr;
  logic        hit_ledg;
  logic        hit_in;
  logic        bad_acc;
  logic [31:0] rd_data;

  assign access = apb_req.psel & apb_req.penable;

  // Offset decode within the GPIO half
  assign hit_ledr = (apb_req.paddr[10:0] == mcpu_pkg::gpio_ledr_off);
  assign hit_ledg = (apb_req.paddr[10:0] == mcpu_pkg::gpio_ledg_off);
  assign hit_in   = (apb_req.paddr[10:0] == mcpu_pkg::gpio_in_off);

  // Unmapped offset or write to the status word
  assign bad_acc = ~(hit_ledr | hit_ledg | hit_in) | (hit_in & apb_req.pwrite);

  // LED registers, written on the edge ending the access cycle
  always_ff @(posedge clk50 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      ledr <= '0;
      ledg <= '0;
    end else if (access && apb_req.pwrite && !bad_acc) begin
      if (hit_ledr) begin
        ledr <= apb_req.pwdata[9:0];
      end
      if (hit_ledg) begin
        ledg <= apb_req.pwdata[7:0];
      end
    end
  end

  // Read mux, status sampled live
  always_comb begin
    rd_data = '0;
    if (hit_ledr) begin
      rd_data[9:0] = ledr;                        // Upper bits read zero
    end else if (hit_ledg) begin
      rd_data[7:0] = ledg;
    end else if (hit_in) begin
      rd_data[9:0]   = pad_in.switches;
      rd_data[13:10] = pad_in.buttons;
      rd_data[14]    = pad_in.uart_rx;
    end
  end

  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = access;
  assign apb_rsp.pslverr = access & bad_acc;

endmodule

/* source/mcpu_apb_decode.sv */
`timescale 1ns/1ns

module mcpu_apb_decode (
  input  mcpu_pkg::apb_req_t apb_req,
  output mcpu_pkg::apb_rsp_t apb_rsp,
  output mcpu_pkg::apb_req_t gpio_req,
  input  mcpu_pkg::apb_rsp_t gpio_rsp,
  output mcpu_pkg::apb_req_t mem_req,
  input  mcpu_pkg::apb_rsp_t mem_rsp
);

  logic mem_sel;                                  // Transfer targets scratch memory

  assign mem_sel = apb_req.paddr[mcpu_pkg::addr_mem_bit];

  // Both slaves see address and data, only one sees psel
  always_comb begin
    gpio_req      = apb_req;
    gpio_req.psel = apb_req.psel & ~mem_sel;
    mem_req       = apb_req;
    mem_req.psel  = apb_req.psel & mem_sel;
  end

  // Response mux
  always_comb begin
    if (!apb_req.psel) begin
      apb_rsp = '0;                               // Idle bus
    end else if (mem_sel) begin
      apb_rsp = mem_rsp;
    end else begin
      apb_rsp = gpio_rsp;
    end
  end

endmodule

/* source/mcpu_pad_in.sv */
`timescale 1ns/1ns

module mcpu_pad_in (
  input  logic              clk50,
  input  logic              rst_n,
  input  logic [9:0]        sw,
  input  logic [3:0]        key,                  // Active low push buttons
  input  logic              uart_rx_pad,
  output mcpu_pkg::pad_in_t pad_in
);

  logic [9:0] sw_meta;                            // First sync stage
  logic [9:0] sw_sync;
  logic [3:0] key_meta;
  logic [3:0] key_sync;
  logic [3:0] uart_sh;                            // Four stage UART line shifter

  // Two flop synchronisers, keys inverted on entry
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      sw_meta  <= '0;
      sw_sync  <= '0;
      key_meta <= '0;                             // Released
      key_sync <= '0;
    end else begin
      sw_meta  <= sw;
      sw_sync  <= sw_meta;
      key_meta <= ~key;
      key_sync <= key_meta;
    end
  end

  // Serial line enters at the top, leaves at bit 0
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      uart_sh <= 4'hf;                            // Idle mark level
    end else begin
      uart_sh <= {uart_rx_pad, uart_sh[3:1]};
    end
  end

  assign pad_in.switches = sw_sync;
  assign pad_in.buttons  = key_sync;
  assign pad_in.uart_rx  = uart_sh[0];

endmodule

/* source/mcpu_clkrst.sv */
`timescale 1ns/1ns

module mcpu_clkrst #(
  parameter int rst_hold = 16                     // Cycles from mem ready to core release
) (
  input  logic clk50,
  input  logic rst_n,
  input  logic mem_ready,
  input  logic reset_button,                      // Conditioned button 0
  output logic core_rst_n
);

  localparam int cnt_w = $clog2(rst_hold + 1);

  logic [cnt_w-1:0] hold_cnt;
  logic             hold_ok;

  // Core may run only with memory up and button released
  assign hold_ok = mem_ready & ~reset_button;

  // Hold counter saturates at rst_hold
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt <= '0;
    end else if (!hold_ok) begin
      hold_cnt <= '0;                             // Button or memory drop restarts the count
    end else if (hold_cnt != cnt_w'(rst_hold)) begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // Async assert by pad reset, sync release
  // Release edge is the one where the counter reaches rst_hold
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      core_rst_n <= 1'b0;
    end else if (!hold_ok) begin
      core_rst_n <= 1'b0;                         // Drops on first edge with button set
    end else begin
      core_rst_n <= (hold_cnt >= cnt_w'(rst_hold - 1));
    end
  end

endmodule

/* source/mcpu_pkg.sv */
package mcpu_pkg;

  // APB bus widths
  localparam int apb_addr_w = 12;
  localparam int apb_data_w = 32;

  // Address map
  localparam int addr_mem_bit = 11;               // High half of the window is scratch memory

  // GPIO register offsets within the low half
  localparam logic [10:0] gpio_ledr_off = 11'h000; // Red LEDs, 10 bits
  localparam logic [10:0] gpio_ledg_off = 11'h004; // Green LEDs, 8 bits
  localparam logic [10:0] gpio_in_off   = 11'h008; // Input status, read only

  // Request from the APB host
  typedef struct packed {
    logic [apb_addr_w-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_data_w-1:0] pwdata;
  } apb_req_t;

  // Response back to the host
  typedef struct packed {
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // Conditioned board inputs
  typedef struct packed {
    logic [9:0] switches;
    logic [3:0] buttons;                          // Active high after inversion
    logic       uart_rx;
  } pad_in_t;

endpackage
